//--- verilog/cordic_pkg.sv
`default_nettype none

package cordic_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and scaling
    localparam int ANGLE_W = 9;
    localparam int DATA_W = 32;
    localparam int IN_SCALE = 10000;
    localparam int DEG_UNITS = 10000;

    // Input angle boundaries, whole degrees
    localparam int FOLD_EDGE_IN = 45;
    localparam int FOLD_EDGE_OUT = 135;
    localparam int QUAD_EDGE = 90;

    //////////////////////////////////////////////////////////////////////
    // Angle constants in units of 0.0001 degree
    localparam int QUARTER_TURN = 900000;
    localparam int HALF_TURN = 1800000;

    localparam int FRIENDLY_HI = 265650;
    localparam int FRIENDLY_LO = 103050;
    localparam int ATAN_FRIENDLY1 = 162600;
    localparam int ATAN_FRIENDLY2 = 368700;

    localparam int USR_THRESH = 35630;
    localparam int ATAN_USR = 71250;

    localparam int NOM_SHIFT_1 = 5;
    localparam int NOM_SHIFT_2 = 6;
    localparam int NOM_SHIFT_3 = 7;
    localparam int ATAN_NOM_1 = 17900;
    localparam int ATAN_NOM_2 = 8950;
    localparam int ATAN_NOM_3 = 4480;

    // Micro rotation, k steps of 0.056 deg
    localparam int MICRO_SHIFT = 10;
    localparam int ATAN_MICRO = 560;
    localparam int MICRO_MAX_K = 8;
    localparam int MICRO_K_W = 5;

    // Input register to normalizer output
    localparam int LATENCY = 11;

    //////////////////////////////////////////////////////////////////////
    // Enums
    typedef enum logic [2:0] {
        FOLD_FAR_NEG,
        FOLD_NEG,
        FOLD_CENTRE,
        FOLD_POS,
        FOLD_FAR_POS
    } fold_region_t;

    typedef enum logic [1:0] {
        QUAD_NEG_FAR,   // -180 .. -90
        QUAD_NEG,       // -90 .. 0
        QUAD_POS,       // 0 .. 90
        QUAD_POS_FAR    // 90 .. 180
    } quadrant_t;

endpackage

`default_nettype wire

//--- verilog/pipe_control.sv
`default_nettype none

module pipe_control
    import cordic_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      in_valid,
    input  wire logic signed [ANGLE_W-1:0] x_in,
    input  wire logic signed [ANGLE_W-1:0] y_in,
    input  wire logic signed [ANGLE_W-1:0] z_in,
    output logic signed [ANGLE_W-1:0]     x_q,
    output logic signed [ANGLE_W-1:0]     y_q,
    output logic signed [ANGLE_W-1:0]     z_q,
    output quadrant_t                      quad_d,
    output logic                           out_valid
);

    logic [LATENCY-1:0] valid_pipe;
    quadrant_t          quad_in;
    quadrant_t          quad_pipe [0:LATENCY-2];

    // Quadrant of the raw input angle
    always_comb
    begin
        if (z_in <= -QUAD_EDGE)
            quad_in = QUAD_NEG_FAR;
        else if (z_in <= 0)
            quad_in = QUAD_NEG;
        else if (z_in <= QUAD_EDGE)
            quad_in = QUAD_POS;
        else
            quad_in = QUAD_POS_FAR;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[LATENCY-2:0], in_valid};
    end

    // Input register plus quadrant delay, one entry short of the valid line
    always_ff @(posedge clk)
    begin
        x_q <= x_in;
        y_q <= y_in;
        z_q <= z_in;
        quad_pipe[0] <= quad_in;
        for (int i = 1; i < LATENCY - 1; i++)
            quad_pipe[i] <= quad_pipe[i-1];
    end

    assign quad_d = quad_pipe[LATENCY-2];
    assign out_valid = valid_pipe[LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/quadrant_fold.sv
`default_nettype none

module quadrant_fold
    import cordic_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic signed [ANGLE_W-1:0] x,
    input  wire logic signed [ANGLE_W-1:0] y,
    input  wire logic signed [ANGLE_W-1:0] z,
    output logic signed [DATA_W-1:0]      x_o,
    output logic signed [DATA_W-1:0]      y_o,
    output logic signed [DATA_W-1:0]      z_o
);

    fold_region_t             region;
    logic signed [DATA_W-1:0] x_s, y_s, z_s;

    // Region from the angle only
    always_comb
    begin
        if (z < -FOLD_EDGE_OUT)
            region = FOLD_FAR_NEG;
        else if (z < -FOLD_EDGE_IN)
            region = FOLD_NEG;
        else if (z < FOLD_EDGE_IN)
            region = FOLD_CENTRE;
        else if (z < FOLD_EDGE_OUT)
            region = FOLD_POS;
        else
            region = FOLD_FAR_POS;
    end

    assign x_s = x * IN_SCALE;
    assign y_s = y * IN_SCALE;
    assign z_s = z * DEG_UNITS;

    always_ff @(posedge clk)
    begin
        case (region)
            FOLD_FAR_NEG:
            begin
                x_o <= -x_s;
                y_o <= -y_s;
                z_o <= z_s + HALF_TURN;
            end
            FOLD_NEG:
            begin
                x_o <= -y_s;
                y_o <= x_s;
                z_o <= z_s + QUARTER_TURN;
            end
            FOLD_POS:
            begin
                x_o <= y_s;
                y_o <= -x_s;
                z_o <= z_s - QUARTER_TURN;
            end
            FOLD_FAR_POS:
            begin
                x_o <= -x_s;
                y_o <= -y_s;
                z_o <= z_s - HALF_TURN;
            end
            default:
            begin
                x_o <= x_s;
                y_o <= y_s;
                z_o <= z_s;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/friendly_stage.sv
`default_nettype none

module friendly_stage
    import cordic_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic signed [DATA_W-1:0] x,
    input  wire logic signed [DATA_W-1:0] y,
    input  wire logic signed [DATA_W-1:0] z,
    output logic signed [DATA_W-1:0]     x_o,
    output logic signed [DATA_W-1:0]     y_o,
    output logic signed [DATA_W-1:0]     z_o
);

    logic signed [5:0]        cf, sf;
    logic signed [DATA_W-1:0] dz;
    logic signed [DATA_W-1:0] rot_x, rot_y, rot_z;

    // 41/1024, close to 1/25
    function automatic logic signed [DATA_W-1:0] div25(input logic signed [DATA_W-1:0] v);
        return (v >>> 5) + (v >>> 6) - (v >>> 8) - (v >>> 9) - (v >>> 10);
    endfunction

    // Integer rotations of magnitude 25
    always_comb
    begin
        if (z < -FRIENDLY_HI)
        begin
            cf = 6'sd20;
            sf = -6'sd15;
            dz = -ATAN_FRIENDLY2;
        end
        else if (z < -FRIENDLY_LO)
        begin
            cf = 6'sd24;
            sf = -6'sd7;
            dz = -ATAN_FRIENDLY1;
        end
        else if (z < FRIENDLY_LO)
        begin
            cf = 6'sd25;
            sf = 6'sd0;
            dz = '0;
        end
        else if (z < FRIENDLY_HI)
        begin
            cf = 6'sd24;
            sf = 6'sd7;
            dz = ATAN_FRIENDLY1;
        end
        else
        begin
            cf = 6'sd20;
            sf = 6'sd15;
            dz = ATAN_FRIENDLY2;
        end
    end

    always_ff @(posedge clk)
    begin
        rot_x <= cf * x + sf * y;
        rot_y <= cf * y - sf * x;
        rot_z <= z - dz;
        // Second step, scale back down
        x_o <= div25(rot_x);
        y_o <= div25(rot_y);
        z_o <= rot_z;
    end

endmodule

`default_nettype wire

//--- verilog/usr_stage.sv
`default_nettype none

module usr_stage
    import cordic_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic signed [DATA_W-1:0] x,
    input  wire logic signed [DATA_W-1:0] y,
    input  wire logic signed [DATA_W-1:0] z,
    output logic signed [DATA_W-1:0]     x_o,
    output logic signed [DATA_W-1:0]     y_o,
    output logic signed [DATA_W-1:0]     z_o
);

    logic signed [8:0]        cu, su;
    logic signed [DATA_W-1:0] dz;
    logic signed [DATA_W-1:0] rot_x, rot_y, rot_z;

    // 1/128 - 1/16384, near 1/129
    function automatic logic signed [DATA_W-1:0] div129(input logic signed [DATA_W-1:0] v);
        return (v >>> 7) - (v >>> 14);
    endfunction

    always_comb
    begin
        if (z < -USR_THRESH)
        begin
            cu = 9'sd128;
            su = -9'sd16;
            dz = -ATAN_USR;
        end
        else if (z < USR_THRESH)
        begin
            cu = 9'sd129;
            su = 9'sd0;
            dz = '0;
        end
        else
        begin
            cu = 9'sd128;
            su = 9'sd16;
            dz = ATAN_USR;
        end
    end

    always_ff @(posedge clk)
    begin
        rot_x <= cu * x + su * y;
        rot_y <= cu * y - su * x;
        rot_z <= z - dz;
        x_o <= div129(rot_x);
        y_o <= div129(rot_y);
        z_o <= rot_z;
    end

endmodule

`default_nettype wire

//--- verilog/nominal_stage.sv
`default_nettype none

module nominal_stage
    import cordic_pkg::*;
#(
    parameter int SHIFT = NOM_SHIFT_1,
    parameter int ATAN  = ATAN_NOM_1
)
(
    input  wire logic                     clk,
    input  wire logic signed [DATA_W-1:0] x,
    input  wire logic signed [DATA_W-1:0] y,
    input  wire logic signed [DATA_W-1:0] z,
    output logic signed [DATA_W-1:0]     x_o,
    output logic signed [DATA_W-1:0]     y_o,
    output logic signed [DATA_W-1:0]     z_o
);

    // Direction follows the sign of the residual angle
    always_ff @(posedge clk)
    begin
        if (z < 0)
        begin
            x_o <= x - (y >>> SHIFT);
            y_o <= y + (x >>> SHIFT);
            z_o <= z + ATAN;
        end
        else
        begin
            x_o <= x + (y >>> SHIFT);
            y_o <= y - (x >>> SHIFT);
            z_o <= z - ATAN;
        end
    end

endmodule

`default_nettype wire

//--- verilog/micro_stage.sv
`default_nettype none

module micro_stage
    import cordic_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic signed [DATA_W-1:0] x,
    input  wire logic signed [DATA_W-1:0] y,
    input  wire logic signed [DATA_W-1:0] z,
    output logic signed [DATA_W-1:0]     x_o,
    output logic signed [DATA_W-1:0]     y_o,
    output logic signed [DATA_W-1:0]     z_o
);

    logic signed [MICRO_K_W-1:0] k;

    // Step count k, z over ATAN_MICRO rounded to nearest
    // Band 0 spans -280 up to just below 280, saturates at 8 steps
    always_comb
    begin
        k = '0;
        for (int m = 1; m <= MICRO_MAX_K; m++)
        begin
            if (z >= m * ATAN_MICRO - ATAN_MICRO / 2)
                k++;
            if (z < ATAN_MICRO / 2 - m * ATAN_MICRO)
                k--;
        end
    end

    always_ff @(posedge clk)
    begin
        x_o <= x + k * (y >>> MICRO_SHIFT);
        y_o <= y - k * (x >>> MICRO_SHIFT);
        z_o <= z - k * ATAN_MICRO;
    end

endmodule

`default_nettype wire

//--- verilog/sign_normalize.sv
`default_nettype none

module sign_normalize
    import cordic_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic signed [DATA_W-1:0] x,
    input  wire logic signed [DATA_W-1:0] y,
    input  wire logic signed [DATA_W-1:0] z,
    input  wire quadrant_t                quad,
    output logic signed [DATA_W-1:0]     x_out,
    output logic signed [DATA_W-1:0]     y_out,
    output logic signed [DATA_W-1:0]     z_out
);

    logic signed [DATA_W-1:0] x_mag, y_mag;

    assign x_mag = x[DATA_W-1] ? -x : x;
    assign y_mag = y[DATA_W-1] ? -y : y;

    // Signs of cos and sin per input quadrant
    always_ff @(posedge clk)
    begin
        case (quad)
            QUAD_NEG_FAR:
            begin
                x_out <= -x_mag;
                y_out <= -y_mag;
            end
            QUAD_NEG:
            begin
                x_out <= x_mag;
                y_out <= -y_mag;
            end
            QUAD_POS:
            begin
                x_out <= x_mag;
                y_out <= y_mag;
            end
            default:
            begin
                x_out <= -x_mag;
                y_out <= y_mag;
            end
        endcase
        z_out <= z;
    end

endmodule

`default_nettype wire

//--- verilog/cordic_top.sv
`default_nettype none

module cordic_top
    import cordic_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      in_valid,
    input  wire logic signed [ANGLE_W-1:0] x_in,
    input  wire logic signed [ANGLE_W-1:0] y_in,
    input  wire logic signed [ANGLE_W-1:0] z_in,
    output logic                           out_valid,
    output logic signed [DATA_W-1:0]      x_out,
    output logic signed [DATA_W-1:0]      y_out,
    output logic signed [DATA_W-1:0]      z_out
);

    logic signed [ANGLE_W-1:0] x_q, y_q, z_q;
    quadrant_t                 quad_d;

    logic signed [DATA_W-1:0] fold_x, fold_y, fold_z;
    logic signed [DATA_W-1:0] fr_x, fr_y, fr_z;
    logic signed [DATA_W-1:0] usr_x, usr_y, usr_z;
    logic signed [DATA_W-1:0] n1_x, n1_y, n1_z;
    logic signed [DATA_W-1:0] n2_x, n2_y, n2_z;
    logic signed [DATA_W-1:0] n3_x, n3_y, n3_z;
    logic signed [DATA_W-1:0] mic_x, mic_y, mic_z;

    //////////////////////////////////////////////////////////////////////
    // Control, input register and quadrant delay
    pipe_control u_ctrl (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid),
        .x_in(x_in), .y_in(y_in), .z_in(z_in),
        .x_q(x_q), .y_q(y_q), .z_q(z_q),
        .quad_d(quad_d), .out_valid(out_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath stages
    quadrant_fold u_fold (
        .clk(clk), .x(x_q), .y(y_q), .z(z_q),
        .x_o(fold_x), .y_o(fold_y), .z_o(fold_z)
    );

    friendly_stage u_friendly (
        .clk(clk), .x(fold_x), .y(fold_y), .z(fold_z),
        .x_o(fr_x), .y_o(fr_y), .z_o(fr_z)
    );

    usr_stage u_usr (
        .clk(clk), .x(fr_x), .y(fr_y), .z(fr_z),
        .x_o(usr_x), .y_o(usr_y), .z_o(usr_z)
    );

    nominal_stage #(.SHIFT(NOM_SHIFT_1), .ATAN(ATAN_NOM_1)) u_nom1 (
        .clk(clk), .x(usr_x), .y(usr_y), .z(usr_z),
        .x_o(n1_x), .y_o(n1_y), .z_o(n1_z)
    );

    nominal_stage #(.SHIFT(NOM_SHIFT_2), .ATAN(ATAN_NOM_2)) u_nom2 (
        .clk(clk), .x(n1_x), .y(n1_y), .z(n1_z),
        .x_o(n2_x), .y_o(n2_y), .z_o(n2_z)
    );

    nominal_stage #(.SHIFT(NOM_SHIFT_3), .ATAN(ATAN_NOM_3)) u_nom3 (
        .clk(clk), .x(n2_x), .y(n2_y), .z(n2_z),
        .x_o(n3_x), .y_o(n3_y), .z_o(n3_z)
    );

    micro_stage u_micro (
        .clk(clk), .x(n3_x), .y(n3_y), .z(n3_z),
        .x_o(mic_x), .y_o(mic_y), .z_o(mic_z)
    );

    // Residual angle rides along with the sign fix
    sign_normalize u_norm (
        .clk(clk), .x(mic_x), .y(mic_y), .z(mic_z), .quad(quad_d),
        .x_out(x_out), .y_out(y_out), .z_out(z_out)
    );

endmodule

`default_nettype wire

//--- testbench/cordic_tb.sv
`default_nettype none

module cordic_tb
    import cordic_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 64;
    localparam int CLK_HALF = 2;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES = 20;
    localparam int DRAIN_CYCLES = 5;

    logic                      clk;
    logic                      arst_n;
    logic                      in_valid;
    logic signed [ANGLE_W-1:0] x_in;
    logic signed [ANGLE_W-1:0] y_in;
    logic signed [ANGLE_W-1:0] z_in;
    logic                      out_valid;
    logic signed [DATA_W-1:0]  x_out;
    logic signed [DATA_W-1:0]  y_out;
    logic signed [DATA_W-1:0]  z_out;

    // Vectors from the stimulus file
    logic signed [ANGLE_W-1:0] vec_x [0:MAX_VEC-1];
    logic signed [ANGLE_W-1:0] vec_y [0:MAX_VEC-1];
    logic signed [ANGLE_W-1:0] vec_z [0:MAX_VEC-1];
    logic signed [DATA_W-1:0]  vec_cos [0:MAX_VEC-1];
    logic signed [DATA_W-1:0]  vec_sin [0:MAX_VEC-1];
    int                        num_vec;

    // Samples in flight, oldest first
    logic signed [DATA_W-1:0] exp_cos_q [$];
    logic signed [DATA_W-1:0] exp_sin_q [$];
    int                       tol_q [$];
    int                       due_q [$];
    int                       id_q [$];

    int     cycle = 0;
    int     timeout_limit = 0;
    int     checks = 0;
    int     errors = 0;
    integer seed;

    cordic_top uut (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid),
        .x_in(x_in), .y_in(y_in), .z_in(z_in),
        .out_valid(out_valid), .x_out(x_out), .y_out(y_out), .z_out(z_out)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #CLK_HALF clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Cycle count and timeout
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            cycle <= 0;
        else
            cycle <= cycle + 1;
    end

    always @(posedge clk)
    begin
        if (timeout_limit > 0 && cycle >= timeout_limit)
        begin
            $display("Timeout at cycle %0d with %0d samples still in flight",
                     cycle, due_q.size());
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic longint abs_diff(input logic signed [DATA_W-1:0] a,
                                        input logic signed [DATA_W-1:0] b);
        longint d;
        d = longint'(a) - longint'(b);
        return (d < 0) ? -d : d;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Scoreboard, outputs are stable at the falling edge
    task automatic check_output();
        logic signed [DATA_W-1:0] exp_c;
        logic signed [DATA_W-1:0] exp_s;
        int                       tol;
        int                       id;
        if (out_valid)
        begin
            if (due_q.size() == 0 || due_q[0] > cycle)
            begin
                $display("Error: out_valid high at cycle %0d with no sample due", cycle);
                errors++;
            end
            else
            begin
                exp_c = exp_cos_q.pop_front();
                exp_s = exp_sin_q.pop_front();
                tol = tol_q.pop_front();
                id = id_q.pop_front();
                void'(due_q.pop_front());
                checks += 3;
                if (abs_diff(x_out, exp_c) > tol)
                begin
                    $display("Fail x_out: got %h expected %h (sample %0d, tolerance %0d)",
                             x_out, exp_c, id, tol);
                    errors++;
                end
                if (abs_diff(y_out, exp_s) > tol)
                begin
                    $display("Fail y_out: got %h expected %h (sample %0d, tolerance %0d)",
                             y_out, exp_s, id, tol);
                    errors++;
                end
                // Residual stays within one micro step
                if (z_out > ATAN_MICRO || z_out < -ATAN_MICRO)
                begin
                    $display("Fail z_out: got %h limit %h (sample %0d)",
                             z_out, ATAN_MICRO, id);
                    errors++;
                end
            end
        end
        else if (due_q.size() != 0 && due_q[0] <= cycle)
        begin
            $display("Error: sample %0d gave no out_valid at cycle %0d", id_q[0], cycle);
            errors++;
            void'(exp_cos_q.pop_front());
            void'(exp_sin_q.pop_front());
            void'(tol_q.pop_front());
            void'(due_q.pop_front());
            void'(id_q.pop_front());
        end
    endtask

    always @(negedge clk)
    begin
        if (arst_n)
            check_output();
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic load_vectors();
        int                fd;
        int                got;
        logic [8*128-1:0]  text;
        logic [DATA_W-1:0] fx, fy, fz, fc, fs;
        num_vec = 0;
        fd = $fopen("testbench/cordic_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Error: cannot open the stimulus file");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && num_vec < MAX_VEC)
            begin
                text = '0;
                got = $fgets(text, fd);
                // Comment and blank lines match no field
                got = $sscanf(text, "%h %h %h %h %h", fx, fy, fz, fc, fs);
                if (got == 5)
                begin
                    vec_x[num_vec] = fx[ANGLE_W-1:0];
                    vec_y[num_vec] = fy[ANGLE_W-1:0];
                    vec_z[num_vec] = fz[ANGLE_W-1:0];
                    vec_cos[num_vec] = fc;
                    vec_sin[num_vec] = fs;
                    num_vec++;
                end
            end
            $fclose(fd);
        end
        if (num_vec == 0)
        begin
            $display("Error: no test vectors were read");
            errors++;
        end
    endtask

    // Called at a falling edge, the sample is taken at the next rising edge
    task automatic drive_sample(input int idx);
        in_valid = 1'b1;
        x_in = vec_x[idx];
        y_in = vec_y[idx];
        z_in = vec_z[idx];
        exp_cos_q.push_back(vec_cos[idx]);
        exp_sin_q.push_back(vec_sin[idx]);
        // 0.2 percent of 10000 * x, plus 4
        tol_q.push_back(vec_x[idx] * IN_SCALE / 500 + 4);
        due_q.push_back(cycle + LATENCY);
        id_q.push_back(idx);
        @(negedge clk);
    endtask

    initial
    begin
        int gap;
        seed = 32'h786a31da;
        arst_n = 1'b0;
        in_valid = 1'b0;
        x_in = '0;
        y_in = '0;
        z_in = '0;
        load_vectors();
        timeout_limit = num_vec * 3 + LATENCY + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Quiet period, out_valid must stay low
        repeat (IDLE_CYCLES) @(negedge clk);

        for (int i = 0; i < num_vec; i++)
        begin
            drive_sample(i);
            // Mostly back to back, sometimes one or two idle cycles
            gap = $random(seed) & 7;
            if (gap > 2)
                gap = 0;
            if (gap != 0)
            begin
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
        end
        in_valid = 1'b0;

        while (due_q.size() != 0)
            @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cordic_stimulus.txt
// x_in y_in z_in (9-bit two's complement), then expected 10000*x*cos(z) and
// 10000*x*sin(z) rounded (32-bit two's complement), all in hex
064 000 14d fff0be58 ffffbbd4
064 000 16a fff2c917 fff85ee0
064 000 179 fff535dd fff535dd
064 000 188 fff85ee0 fff2c917
064 000 1a5 ffffbbd4 fff0be58
064 000 1a6 00000000 fff0bdc0
064 000 1c4 0007a120 fff2c917
064 000 1d3 000aca23 fff535dd
064 000 1e2 000d36e9 fff85ee0
064 000 1f6 000f06e8 fffd59b0
064 000 1ff 000f41a8 ffffbbd4
064 000 000 000f4240 00000000
064 000 001 000f41a8 0000442c
064 000 00a 000f06e8 0002a650
064 000 01e 000d36e9 0007a120
064 000 02d 000aca23 000aca23
064 000 03c 0007a120 000d36e9
064 000 059 0000442c 000f41a8
064 000 05a 00000000 000f4240
064 000 064 fffd59b0 000f06e8
064 000 078 fff85ee0 000d36e9
064 000 087 fff535dd 000aca23
064 000 096 fff2c917 0007a120
064 000 0aa fff0f918 0002a650
064 000 0b4 fff0bdc0 00000000
001 000 01e 000021d4 00001388
032 000 01e 00069b75 0003d090
0ff 000 01e 0021b26d 00137478
032 000 04b 0001f982 00075e93
032 000 179 fffa9aef fffa9aef
0ff 000 001 0026e76c 0000add8
0ff 000 19c fff93e4d ffd9ae64
0ff 000 087 ffe47c8e 001b8372

//--- all.f
verilog/cordic_pkg.sv
verilog/pipe_control.sv
verilog/quadrant_fold.sv
verilog/friendly_stage.sv
verilog/usr_stage.sv
verilog/nominal_stage.sv
verilog/micro_stage.sv
verilog/sign_normalize.sv
verilog/cordic_top.sv
testbench/cordic_tb.sv
